//--- Makefile
# Verilator build and run of the csr_unit testbench.

VERILATOR ?= verilator
TOP       ?= tb_csr_unit
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= Test OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- src/csr_bus_if.sv
// ----------------------------------------
// CSR write port and read address shared by the register blocks.
// ----------------------------------------
`include "csr_settings.svh"

interface csr_bus_if;

    logic             csr_wr;
    logic [11:0]      csr_waddr;
    logic [`XLEN-1:0] csr_wdata;
    logic [11:0]      csr_raddr;

    modport src (output csr_wr, output csr_waddr, output csr_wdata, output csr_raddr);

    // write on a rising edge with csr_wr high, read combinational.
    modport dst (input csr_wr, input csr_waddr, input csr_wdata, input csr_raddr);

endinterface

//--- src/csr_pkg.sv
// ----------------------------------------
// shared types of the trap unit, used by scoped name.
// ----------------------------------------
`include "csr_settings.svh"

package csr_pkg;

    // data word and instruction address.
    typedef logic [`XLEN-1:0] xlen_t;
    typedef logic [`XLEN-1:0] addr_t;

    typedef logic [11:0] csr_addr_t;

    typedef logic [`CAUSE_W-1:0] cause_code_t;

    // pending interrupts, bit 2 MEI, bit 1 MSI, bit 0 MTI.
    typedef logic [2:0] irq_vec_t;

    typedef enum logic [1:0] {
        PRV_U = 2'd0,
        PRV_M = 2'd3
    } priv_e;

endpackage

//--- src/csr_settings.svh
// ----------------------------------------
// widths, CSR addresses and bit positions of the machine trap unit.
// ----------------------------------------
`ifndef CSR_SETTINGS_SVH
`define CSR_SETTINGS_SVH

`define XLEN         32
`define CAUSE_W      5

// machine trap CSR addresses.
`define CSR_MSTATUS  12'h300
`define CSR_MIE      12'h304
`define CSR_MTVEC    12'h305
`define CSR_MSCRATCH 12'h340
`define CSR_MEPC     12'h341
`define CSR_MCAUSE   12'h342
`define CSR_MTVAL    12'h343
`define CSR_MIP      12'h344

// bit in mip/mie, also the interrupt cause code.
`define IRQ_MSI      3
`define IRQ_MTI      7
`define IRQ_MEI      11

`define MSTATUS_MIE  3
`define MSTATUS_MPIE 7
`define MSTATUS_MPP  12:11

`endif

//--- src/csr_unit.sv
// ----------------------------------------
// top of the machine trap unit, with flat ports to the core.
// ----------------------------------------
module csr_unit (
    input  logic                 clk,
    input  logic                 srstn,
    input  logic                 ext_msip,
    input  logic                 ext_mtip,
    input  logic                 ext_meip,
    input  logic                 int_mask,
    input  logic                 trap_en,
    input  csr_pkg::addr_t       trap_epc,
    input  csr_pkg::xlen_t       trap_cause,
    input  csr_pkg::xlen_t       trap_val,
    input  logic                 mret,
    input  logic                 csr_wr,
    input  csr_pkg::csr_addr_t   csr_waddr,
    input  csr_pkg::csr_addr_t   csr_raddr,
    input  csr_pkg::xlen_t       csr_wdata,
    output logic                 wakeup,
    output logic                 irq_trigger,
    output logic                 eret_en,
    output csr_pkg::priv_e       prv,
    output csr_pkg::xlen_t       cause,
    output csr_pkg::xlen_t       tval,
    output csr_pkg::addr_t       trap_vec,
    output csr_pkg::addr_t       ret_epc,
    output csr_pkg::xlen_t       csr_rdata
);

    csr_bus_if bus ();
    trap_if    trap ();

    csr_pkg::irq_vec_t enabled_pend;
    logic              mstatus_mie;
    csr_pkg::priv_e    mstatus_mpp;
    csr_pkg::xlen_t    irq_rdata;
    csr_pkg::xlen_t    status_rdata;
    csr_pkg::xlen_t    trap_rdata;

    assign bus.csr_wr    = csr_wr;
    assign bus.csr_waddr = csr_waddr;
    assign bus.csr_wdata = csr_wdata;
    assign bus.csr_raddr = csr_raddr;

    trap_ctrl u_trap_ctrl (.clk(clk), .srstn(srstn), .trap_en(trap_en), .mret(mret),
        .int_mask(int_mask), .enabled_pend(enabled_pend), .mstatus_mie(mstatus_mie),
        .mstatus_mpp(mstatus_mpp), .trap(trap.ctrl), .irq_trigger(irq_trigger),
        .eret_en(eret_en), .prv(prv));

    irq_unit u_irq_unit (.clk(clk), .srstn(srstn), .ext_msip(ext_msip), .ext_mtip(ext_mtip),
        .ext_meip(ext_meip), .bus(bus.dst), .enabled_pend(enabled_pend), .wakeup(wakeup),
        .rdata(irq_rdata));

    status_regs u_status_regs (.clk(clk), .srstn(srstn), .bus(bus.dst), .trap(trap.regs),
        .mstatus_mie(mstatus_mie), .mstatus_mpp(mstatus_mpp), .trap_vec(trap_vec),
        .rdata(status_rdata));

    trap_regs u_trap_regs (.clk(clk), .srstn(srstn), .bus(bus.dst), .trap(trap.regs),
        .trap_epc(trap_epc), .trap_cause(trap_cause), .trap_val(trap_val), .cause(cause),
        .tval(tval), .ret_epc(ret_epc), .rdata(trap_rdata));

    // each block returns zero outside its own addresses.
    assign csr_rdata = irq_rdata | status_rdata | trap_rdata;

endmodule

//--- src/irq_unit.sv
// ----------------------------------------
// interrupt synchronizers, mip and mie, and the enabled pending set.
// ----------------------------------------
`include "csr_settings.svh"

module irq_unit (
    input  logic              clk,
    input  logic              srstn,
    input  logic              ext_msip,
    input  logic              ext_mtip,
    input  logic              ext_meip,
    csr_bus_if.dst            bus,
    output csr_pkg::irq_vec_t enabled_pend,
    output logic              wakeup,
    output csr_pkg::xlen_t    rdata
);

    csr_pkg::irq_vec_t irq_meta;
    csr_pkg::irq_vec_t mip;
    csr_pkg::irq_vec_t mie;

    // place the packed bits at their mip/mie positions.
    function automatic csr_pkg::xlen_t to_word(csr_pkg::irq_vec_t v);
        csr_pkg::xlen_t w;
        w           = '0;
        w[`IRQ_MEI] = v[2];
        w[`IRQ_MSI] = v[1];
        w[`IRQ_MTI] = v[0];
        return w;
    endfunction

    // two flops from the pins into mip.
    always_ff @(posedge clk or negedge srstn) begin
        if (!srstn) begin
            irq_meta <= '0;
            mip      <= '0;
        end else begin
            irq_meta <= {ext_meip, ext_msip, ext_mtip};
            mip      <= irq_meta;
        end
    end

    always_ff @(posedge clk or negedge srstn) begin
        if (!srstn) begin
            mie <= '0;
        end else if (bus.csr_wr && bus.csr_waddr == `CSR_MIE) begin
            mie <= {bus.csr_wdata[`IRQ_MEI], bus.csr_wdata[`IRQ_MSI], bus.csr_wdata[`IRQ_MTI]};
        end
    end

    assign enabled_pend = mip & mie;
    assign wakeup       = |enabled_pend;

    always_comb begin
        case (bus.csr_raddr)
            `CSR_MIE: rdata = to_word(mie);
            `CSR_MIP: rdata = to_word(mip);
            default:  rdata = '0;
        endcase
    end

endmodule

//--- src/status_regs.sv
// ----------------------------------------
// mstatus, mtvec and mscratch, and the trap vector.
// ----------------------------------------
`include "csr_settings.svh"

module status_regs (
    input  logic           clk,
    input  logic           srstn,
    csr_bus_if.dst         bus,
    trap_if.regs           trap,
    output logic           mstatus_mie,
    output csr_pkg::priv_e mstatus_mpp,
    output csr_pkg::addr_t trap_vec,
    output csr_pkg::xlen_t rdata
);

    logic           mstatus_mpie;
    csr_pkg::xlen_t mstatus;
    csr_pkg::xlen_t mtvec;
    csr_pkg::xlen_t mscratch;
    csr_pkg::addr_t vec_offset;

    always_ff @(posedge clk or negedge srstn) begin
        if (!srstn) begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mstatus_mpp  <= csr_pkg::PRV_U;
        end else if (trap.take_exc || trap.take_int) begin
            mstatus_mpp  <= csr_pkg::priv_e'(trap.prv);
            mstatus_mpie <= mstatus_mie;
            mstatus_mie  <= 1'b0;
        end else if (trap.do_mret) begin
            mstatus_mie  <= mstatus_mpie;
            mstatus_mpie <= 1'b1;
            mstatus_mpp  <= csr_pkg::PRV_U;
        end else if (bus.csr_wr && bus.csr_waddr == `CSR_MSTATUS) begin
            mstatus_mie  <= bus.csr_wdata[`MSTATUS_MIE];
            mstatus_mpie <= bus.csr_wdata[`MSTATUS_MPIE];
            // only machine and user exist, anything but 3 falls to user.
            mstatus_mpp  <= (bus.csr_wdata[`MSTATUS_MPP] == 2'b11) ? csr_pkg::PRV_M
                                                                  : csr_pkg::PRV_U;
        end
    end

    always_ff @(posedge clk or negedge srstn) begin
        if (!srstn) begin
            mtvec    <= '0;
            mscratch <= '0;
        end else if (bus.csr_wr) begin
            if (bus.csr_waddr == `CSR_MTVEC) mtvec <= bus.csr_wdata & ~csr_pkg::xlen_t'(2);
            if (bus.csr_waddr == `CSR_MSCRATCH) mscratch <= bus.csr_wdata;
        end
    end

    // vectored mode adds 4 x cause for interrupts only.
    assign vec_offset = (trap.take_int && mtvec[0]) ?
                        {{(`XLEN-`CAUSE_W-2){1'b0}}, trap.int_code, 2'b00} : '0;
    assign trap_vec   = (mtvec & ~csr_pkg::addr_t'(3)) + vec_offset;

    always_comb begin
        mstatus                = '0;
        mstatus[`MSTATUS_MIE]  = mstatus_mie;
        mstatus[`MSTATUS_MPIE] = mstatus_mpie;
        mstatus[`MSTATUS_MPP]  = mstatus_mpp;
    end

    always_comb begin
        case (bus.csr_raddr)
            `CSR_MSTATUS:  rdata = mstatus;
            `CSR_MTVEC:    rdata = mtvec;
            `CSR_MSCRATCH: rdata = mscratch;
            default:       rdata = '0;
        endcase
    end

endmodule

//--- src/trap_ctrl.sv
// ----------------------------------------
// ranks exception, interrupt and mret, and holds the privilege mode.
// ----------------------------------------
`include "csr_settings.svh"

module trap_ctrl (
    input  logic                clk,
    input  logic                srstn,
    input  logic                trap_en,
    input  logic                mret,
    input  logic                int_mask,
    input  csr_pkg::irq_vec_t   enabled_pend,
    input  logic                mstatus_mie,
    input  csr_pkg::priv_e      mstatus_mpp,
    trap_if.ctrl                trap,
    output logic                irq_trigger,
    output logic                eret_en,
    output csr_pkg::priv_e      prv
);

    logic                 int_ok;
    logic                 take_int;
    csr_pkg::cause_code_t int_code;

    // user mode is always interruptible by machine interrupts.
    assign int_ok = (prv == csr_pkg::PRV_U) || mstatus_mie;

    assign take_int = !trap_en && !int_mask && (|enabled_pend) && int_ok;

    // fixed priority MEI, MSI, MTI.
    always_comb begin
        if (enabled_pend[2]) begin
            int_code = csr_pkg::cause_code_t'(`IRQ_MEI);
        end else if (enabled_pend[1]) begin
            int_code = csr_pkg::cause_code_t'(`IRQ_MSI);
        end else begin
            int_code = csr_pkg::cause_code_t'(`IRQ_MTI);
        end
    end

    assign trap.take_exc = trap_en;
    assign trap.take_int = take_int;
    assign trap.do_mret  = mret && !trap_en && !take_int;
    assign trap.int_code = int_code;
    assign trap.prv      = prv;

    assign irq_trigger = take_int;
    assign eret_en     = mret && !trap_en;

    always_ff @(posedge clk or negedge srstn) begin
        if (!srstn) begin
            prv <= csr_pkg::PRV_M;
        end else if (trap_en || take_int) begin
            prv <= csr_pkg::PRV_M;
        end else if (trap.do_mret) begin
            prv <= mstatus_mpp;
        end
    end

endmodule

//--- src/trap_if.sv
// ----------------------------------------
// ranked trap strobes from the control block to the registers.
// ----------------------------------------
`include "csr_settings.svh"

interface trap_if;

    // at most one of the three strobes is high.
    logic               take_exc;
    logic               take_int;
    logic               do_mret;
    logic [`CAUSE_W-1:0] int_code;
    logic [1:0]         prv;

    modport ctrl (
        output take_exc,
        output take_int,
        output do_mret,
        output int_code,
        output prv
    );

    modport regs (
        input take_exc,
        input take_int,
        input do_mret,
        input int_code,
        input prv
    );

endinterface

//--- src/trap_regs.sv
// ----------------------------------------
// mepc, mcause and mtval, with the live cause and tval outputs.
// ----------------------------------------
`include "csr_settings.svh"

module trap_regs (
    input  logic           clk,
    input  logic           srstn,
    csr_bus_if.dst         bus,
    trap_if.regs           trap,
    input  csr_pkg::addr_t trap_epc,
    input  csr_pkg::xlen_t trap_cause,
    input  csr_pkg::xlen_t trap_val,
    output csr_pkg::xlen_t cause,
    output csr_pkg::xlen_t tval,
    output csr_pkg::addr_t ret_epc,
    output csr_pkg::xlen_t rdata
);

    csr_pkg::addr_t       mepc;
    logic                 mcause_int;
    csr_pkg::cause_code_t mcause_code;
    csr_pkg::xlen_t       mcause;
    csr_pkg::xlen_t       mtval;
    csr_pkg::xlen_t       int_cause;

    always_ff @(posedge clk or negedge srstn) begin
        if (!srstn) begin
            mepc        <= '0;
            mcause_int  <= 1'b0;
            mcause_code <= '0;
            mtval       <= '0;
        end else if (trap.take_exc) begin
            mepc        <= trap_epc;
            mcause_int  <= trap_cause[`XLEN-1];
            mcause_code <= trap_cause[`CAUSE_W-1:0];
            mtval       <= trap_val;
        end else if (trap.take_int) begin
            mepc        <= trap_epc;
            mcause_int  <= 1'b1;
            mcause_code <= trap.int_code;
            mtval       <= '0;
        end else if (bus.csr_wr) begin
            case (bus.csr_waddr)
                `CSR_MEPC: mepc <= bus.csr_wdata & ~csr_pkg::addr_t'(1);
                `CSR_MCAUSE: begin
                    mcause_int  <= bus.csr_wdata[`XLEN-1];
                    mcause_code <= bus.csr_wdata[`CAUSE_W-1:0];
                end
                `CSR_MTVAL: mtval <= bus.csr_wdata;
                default: ;
            endcase
        end
    end

    assign mcause    = {mcause_int, {(`XLEN-`CAUSE_W-1){1'b0}}, mcause_code};
    assign int_cause = {1'b1, {(`XLEN-`CAUSE_W-1){1'b0}}, trap.int_code};

    assign cause   = trap.take_exc ? trap_cause : (trap.take_int ? int_cause : '0);
    assign tval    = trap.take_exc ? trap_val : '0;
    assign ret_epc = mepc;

    always_comb begin
        case (bus.csr_raddr)
            `CSR_MEPC:   rdata = mepc;
            `CSR_MCAUSE: rdata = mcause;
            `CSR_MTVAL:  rdata = mtval;
            default:     rdata = '0;
        endcase
    end

endmodule

//--- tests/tb_csr_model.svh
// ----------------------------------------
// cycle model, random source and compare tasks, included inside tb_csr_unit.
// ----------------------------------------
`ifndef TB_CSR_MODEL_SVH
`define TB_CSR_MODEL_SVH

// shadow copy of the architectural state.
logic              sh_mie;
logic              sh_mpie;
csr_pkg::priv_e    sh_mpp;
csr_pkg::priv_e    sh_prv;
csr_pkg::xlen_t    sh_mtvec;
csr_pkg::xlen_t    sh_mscratch;
csr_pkg::addr_t    sh_mepc;
csr_pkg::xlen_t    sh_mcause;
csr_pkg::xlen_t    sh_mtval;
csr_pkg::irq_vec_t sh_ie;
csr_pkg::irq_vec_t sh_sync;
csr_pkg::irq_vec_t sh_ip;
logic [31:0]       rng_state;
int                err_count = 0;
int                check_count = 0;

function automatic logic [31:0] xorshift32(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
endfunction

function automatic csr_pkg::xlen_t irq_word(csr_pkg::irq_vec_t v);
    csr_pkg::xlen_t w;
    w           = '0;
    w[`IRQ_MEI] = v[2];
    w[`IRQ_MSI] = v[1];
    w[`IRQ_MTI] = v[0];
    return w;
endfunction

function automatic csr_pkg::xlen_t make_cause(logic intr, csr_pkg::cause_code_t code);
    return {intr, {(`XLEN - `CAUSE_W - 1){1'b0}}, code};
endfunction

function automatic csr_pkg::xlen_t read_model(csr_pkg::csr_addr_t a);
    csr_pkg::xlen_t w;
    w = '0;
    case (a)
        `CSR_MSTATUS: begin
            w[`MSTATUS_MIE]  = sh_mie;
            w[`MSTATUS_MPIE] = sh_mpie;
            w[`MSTATUS_MPP]  = sh_mpp;
        end
        `CSR_MIE:      w = irq_word(sh_ie);
        `CSR_MIP:      w = irq_word(sh_ip);
        `CSR_MTVEC:    w = sh_mtvec;
        `CSR_MSCRATCH: w = sh_mscratch;
        `CSR_MEPC:     w = sh_mepc;
        `CSR_MCAUSE:   w = sh_mcause;
        `CSR_MTVAL:    w = sh_mtval;
        default:       w = '0;
    endcase
    return w;
endfunction

function automatic logic int_taken();
    logic enabled;
    enabled = (sh_prv == csr_pkg::PRV_U) || sh_mie;
    return !trap_en && !int_mask && (|(sh_ip & sh_ie)) && enabled;
endfunction

// MEI first, then MSI, then MTI.
function automatic csr_pkg::cause_code_t win_code();
    csr_pkg::irq_vec_t pend;
    pend = sh_ip & sh_ie;
    if (pend[2]) begin
        return csr_pkg::cause_code_t'(`IRQ_MEI);
    end else if (pend[1]) begin
        return csr_pkg::cause_code_t'(`IRQ_MSI);
    end
    return csr_pkg::cause_code_t'(`IRQ_MTI);
endfunction

function automatic csr_pkg::xlen_t exp_cause();
    if (trap_en) begin
        return trap_cause;
    end else if (int_taken()) begin
        return make_cause(1'b1, win_code());
    end
    return '0;
endfunction

function automatic csr_pkg::addr_t exp_vec();
    csr_pkg::addr_t base;
    base = sh_mtvec & ~32'h3;
    if (int_taken() && sh_mtvec[0]) begin
        base = base + (csr_pkg::addr_t'(win_code()) << 2);
    end
    return base;
endfunction

task automatic reset_model();
    sh_mie      = 1'b0;
    sh_mpie     = 1'b0;
    sh_mpp      = csr_pkg::PRV_U;
    sh_prv      = csr_pkg::PRV_M;
    sh_mtvec    = '0;
    sh_mscratch = '0;
    sh_mepc     = '0;
    sh_mcause   = '0;
    sh_mtval    = '0;
    sh_ie       = '0;
    sh_sync     = '0;
    sh_ip       = '0;
endtask

// next state from the inputs that are held until the coming rising edge.
task automatic advance_model();
    logic                 take_int;
    logic                 trap;
    csr_pkg::cause_code_t code;
    take_int = int_taken();
    code     = win_code();
    trap     = trap_en || take_int;
    if (trap) begin
        sh_mpp    = sh_prv;
        sh_mpie   = sh_mie;
        sh_mie    = 1'b0;
        sh_prv    = csr_pkg::PRV_M;
        sh_mepc   = trap_epc;
        sh_mcause = trap_en ? make_cause(trap_cause[31], trap_cause[`CAUSE_W-1:0])
                            : make_cause(1'b1, code);
        sh_mtval  = trap_en ? trap_val : '0;
    end else if (mret) begin
        sh_mie  = sh_mpie;
        sh_mpie = 1'b1;
        sh_prv  = sh_mpp;
        sh_mpp  = csr_pkg::PRV_U;
    end
    // a write lands only on registers that the event leaves alone.
    if (csr_wr) begin
        case (csr_waddr)
            `CSR_MSTATUS: begin
                if (!trap && !mret) begin
                    sh_mie  = csr_wdata[`MSTATUS_MIE];
                    sh_mpie = csr_wdata[`MSTATUS_MPIE];
                    sh_mpp  = (csr_wdata[`MSTATUS_MPP] == 2'b11) ? csr_pkg::PRV_M
                                                                 : csr_pkg::PRV_U;
                end
            end
            `CSR_MIE: begin
                sh_ie = {csr_wdata[`IRQ_MEI], csr_wdata[`IRQ_MSI], csr_wdata[`IRQ_MTI]};
            end
            `CSR_MTVEC:    sh_mtvec = csr_wdata & ~32'h2;
            `CSR_MSCRATCH: sh_mscratch = csr_wdata;
            `CSR_MEPC: begin
                if (!trap) sh_mepc = csr_wdata & ~32'h1;
            end
            `CSR_MCAUSE: begin
                if (!trap) sh_mcause = make_cause(csr_wdata[31], csr_wdata[`CAUSE_W-1:0]);
            end
            `CSR_MTVAL: begin
                if (!trap) sh_mtval = csr_wdata;
            end
            default: ;
        endcase
    end
    sh_ip   = sh_sync;
    sh_sync = pins;
endtask

task automatic check_word(string name, csr_pkg::xlen_t act, csr_pkg::xlen_t exp);
    check_count++;
    if (act !== exp) begin
        err_count++;
        $display("Error at %0t: %s is %h, expected %h", $time, name, act, exp);
    end
endtask

task automatic check_addr(string name, csr_pkg::addr_t act, csr_pkg::addr_t exp);
    check_count++;
    if (act !== exp) begin
        err_count++;
        $display("Error at %0t: %s is %h, expected %h", $time, name, act, exp);
    end
endtask

task automatic check_prv(string name, csr_pkg::priv_e act, csr_pkg::priv_e exp);
    check_count++;
    if (act !== exp) begin
        err_count++;
        $display("Error at %0t: %s is %0d, expected %0d", $time, name, act, exp);
    end
endtask

task automatic check_bit(string name, logic act, logic exp);
    check_count++;
    if (act !== exp) begin
        err_count++;
        $display("Error at %0t: %s is %b, expected %b", $time, name, act, exp);
    end
endtask

`endif

//--- tests/tb_csr_unit.sv
// ----------------------------------------
// self-checking testbench of csr_unit against a cycle model.
// ----------------------------------------
`include "csr_settings.svh"

module tb_csr_unit;

    localparam int PERIOD       = 8;
    localparam int RESET_CYCLES = 2;
    localparam int RT_ROUNDS    = 48;
    localparam int EXC_ROUNDS   = 8;
    localparam int IRQ_ROUNDS   = 4;
    // test lengths plus a margin for setup, mret and masking.
    localparam int MAX_CYCLES   = RESET_CYCLES + 2 * (8 + RT_ROUNDS) + 6 * EXC_ROUNDS
                                  + 12 * IRQ_ROUNDS + 100;

    logic               clk;
    logic               srstn;
    csr_pkg::irq_vec_t  pins;
    logic               int_mask;
    logic               trap_en;
    csr_pkg::addr_t     trap_epc;
    csr_pkg::xlen_t     trap_cause;
    csr_pkg::xlen_t     trap_val;
    logic               mret;
    logic               csr_wr;
    csr_pkg::csr_addr_t csr_waddr;
    csr_pkg::csr_addr_t csr_raddr;
    csr_pkg::xlen_t     csr_wdata;
    logic               wakeup;
    logic               irq_trigger;
    logic               eret_en;
    csr_pkg::priv_e     prv;
    csr_pkg::xlen_t     cause;
    csr_pkg::xlen_t     tval;
    csr_pkg::addr_t     trap_vec;
    csr_pkg::addr_t     ret_epc;
    csr_pkg::xlen_t     csr_rdata;
    int                 irq_seen = 0;
    int                 wake_seen = 0;
    int                 fail_count;
    int                 test_start;
    int                 tests_run;
    int                 tests_failed;

`include "tb_csr_model.svh"

    csr_unit DUT (
        .clk(clk), .srstn(srstn), .ext_msip(pins[1]), .ext_mtip(pins[0]), .ext_meip(pins[2]),
        .int_mask(int_mask), .trap_en(trap_en), .trap_epc(trap_epc), .trap_cause(trap_cause),
        .trap_val(trap_val), .mret(mret), .csr_wr(csr_wr), .csr_waddr(csr_waddr),
        .csr_raddr(csr_raddr), .csr_wdata(csr_wdata), .wakeup(wakeup),
        .irq_trigger(irq_trigger), .eret_en(eret_en), .prv(prv), .cause(cause), .tval(tval),
        .trap_vec(trap_vec), .ret_epc(ret_epc), .csr_rdata(csr_rdata)
    );

    always #(PERIOD / 2) clk = ~clk;

    // outputs are settled at the falling edge.
    always @(negedge clk) begin
        if (srstn !== 1'b1) begin
            reset_model();
        end else begin
            check_word("csr_rdata", csr_rdata, read_model(csr_raddr));
            check_word("cause", cause, exp_cause());
            check_word("tval", tval, trap_en ? trap_val : 32'h0);
            check_addr("trap_vec", trap_vec, exp_vec());
            check_addr("ret_epc", ret_epc, sh_mepc);
            check_prv("prv", prv, sh_prv);
            check_bit("irq_trigger", irq_trigger, int_taken());
            check_bit("eret_en", eret_en, mret && !trap_en);
            check_bit("wakeup", wakeup, |(sh_ip & sh_ie));
            if (irq_trigger) begin
                irq_seen++;
            end
            if (wakeup) begin
                wake_seen++;
            end
            advance_model();
        end
    end

    function automatic csr_pkg::csr_addr_t csr_at(logic [2:0] i);
        case (i)
            3'd0:    return `CSR_MSTATUS;
            3'd1:    return `CSR_MIE;
            3'd2:    return `CSR_MTVEC;
            3'd3:    return `CSR_MSCRATCH;
            3'd4:    return `CSR_MEPC;
            3'd5:    return `CSR_MCAUSE;
            3'd6:    return `CSR_MTVAL;
            default: return `CSR_MIP;
        endcase
    endfunction

    // half of the picks are any 12-bit address.
    function automatic csr_pkg::csr_addr_t pick_addr(logic [31:0] r);
        return r[3] ? r[31:20] : csr_at(r[2:0]);
    endfunction

    task automatic tick();
        @(posedge clk);
        trap_en <= 1'b0;
        mret    <= 1'b0;
        csr_wr  <= 1'b0;
    endtask

    task automatic write_csr(csr_pkg::csr_addr_t a, csr_pkg::xlen_t d);
        csr_wr    <= 1'b1;
        csr_waddr <= a;
        csr_wdata <= d;
        tick();
    endtask

    task automatic read_csr(csr_pkg::csr_addr_t a);
        csr_raddr <= a;
        tick();
    endtask

    task automatic raise_exception();
        trap_en    <= 1'b1;
        trap_epc   <= next_rand();
        trap_cause <= next_rand();
        trap_val   <= next_rand();
        csr_raddr  <= `CSR_MCAUSE;
        tick();
    endtask

    task automatic return_from_trap();
        mret      <= 1'b1;
        csr_raddr <= `CSR_MSTATUS;
        tick();
    endtask

    task automatic note_failure(string msg);
        fail_count++;
        $display("%s (time %0t)", msg, $time);
    endtask

    // the line was raised at the last edge and must win two edges later.
    task automatic wait_interrupt();
        int   edges;
        logic seen;
        edges = 0;
        seen  = 1'b0;
        while (!seen && edges < 4) begin
            @(negedge clk);
            if (irq_trigger) begin
                seen = 1'b1;
            end else begin
                edges++;
            end
        end
        @(posedge clk);
        if (!seen) begin
            note_failure("no interrupt was taken within 4 cycles");
        end else if (edges != 2) begin
            note_failure($sformatf("interrupt taken %0d edges after the line rose", edges));
        end
    endtask

    task automatic finish_test(string name);
        int errors;
        tick();
        errors = err_count + fail_count - test_start;
        tests_run++;
        if (errors == 0) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors);
        end
        test_start = err_count + fail_count;
    endtask

    task automatic round_trip_csrs();
        csr_pkg::csr_addr_t a;
        for (int i = 0; i < 8; i++) begin
            a = csr_at(3'(i));
            write_csr(a, next_rand());
            read_csr(a);
        end
        for (int i = 0; i < RT_ROUNDS; i++) begin
            a = pick_addr(next_rand());
            write_csr(a, next_rand());
            read_csr(a);
        end
        finish_test("csr round trip");
    endtask

    task automatic take_exceptions();
        // exceptions ignore the vectored mode.
        write_csr(`CSR_MTVEC, next_rand() | 32'h1);
        for (int i = 0; i < EXC_ROUNDS; i++) begin
            write_csr(`CSR_MSTATUS, next_rand());
            raise_exception();
            read_csr(`CSR_MEPC);
            read_csr(`CSR_MTVAL);
            read_csr(`CSR_MSTATUS);
        end
        finish_test("exceptions");
    endtask

    task automatic return_with_mret();
        write_csr(`CSR_MEPC, next_rand());
        write_csr(`CSR_MSTATUS, 32'h0000_0080);
        return_from_trap();
        read_csr(`CSR_MSTATUS);
        raise_exception();
        read_csr(`CSR_MSTATUS);
        // the exception wins over a return in the same cycle.
        trap_en <= 1'b1;
        mret    <= 1'b1;
        tick();
        read_csr(`CSR_MSTATUS);
        write_csr(`CSR_MSTATUS, 32'h0000_1800);
        return_from_trap();
        read_csr(`CSR_MSTATUS);
        finish_test("mret");
    endtask

    task automatic rank_interrupts();
        write_csr(`CSR_MIE, 32'h0000_0888);
        write_csr(`CSR_MTVEC, (next_rand() & ~32'h3) | 32'h1);
        write_csr(`CSR_MSTATUS, 32'h0000_1808);
        for (int i = 0; i < IRQ_ROUNDS; i++) begin
            case (i)
                0:       pins <= 3'b111;
                1:       pins <= 3'b011;
                2:       pins <= 3'b001;
                default: pins <= 3'b110;
            endcase
            csr_raddr <= `CSR_MCAUSE;
            wait_interrupt();
            read_csr(`CSR_MCAUSE);
            read_csr(`CSR_MTVAL);
            pins <= 3'b000;
            repeat (3) tick();
            return_from_trap();
        end
        finish_test("interrupts");
    endtask

    task automatic mask_interrupts();
        int irq_before;
        int wake_before;
        write_csr(`CSR_MSTATUS, 32'h0000_1800);
        irq_before  = irq_seen;
        wake_before = wake_seen;
        pins <= 3'b100;
        repeat (5) tick();
        int_mask <= 1'b1;
        write_csr(`CSR_MSTATUS, 32'h0000_1808);
        repeat (3) tick();
        if (irq_seen != irq_before) begin
            note_failure("an interrupt was taken while it was masked");
        end
        if (wake_seen == wake_before) begin
            note_failure("wakeup stayed low while an interrupt was pending");
        end
        pins <= 3'b000;
        repeat (3) tick();
        int_mask <= 1'b0;
        // user mode takes machine interrupts with MIE clear.
        write_csr(`CSR_MSTATUS, 32'h0000_0000);
        return_from_trap();
        pins <= 3'b010;
        wait_interrupt();
        read_csr(`CSR_MSTATUS);
        finish_test("masking");
    endtask

    initial begin
        clk          = 1'b0;
        rng_state    = 32'h8454_5868;
        fail_count   = 0;
        test_start   = 0;
        tests_run    = 0;
        tests_failed = 0;
        srstn      <= 1'b0;
        pins       <= '0;
        int_mask   <= 1'b0;
        trap_en    <= 1'b0;
        trap_epc   <= '0;
        trap_cause <= '0;
        trap_val   <= '0;
        mret       <= 1'b0;
        csr_wr     <= 1'b0;
        csr_waddr  <= '0;
        csr_raddr  <= '0;
        csr_wdata  <= '0;
        repeat (RESET_CYCLES) @(posedge clk);
        srstn <= 1'b1;
        round_trip_csrs();
        take_exceptions();
        return_with_mret();
        rank_interrupts();
        mask_interrupts();
        $display("tests: %0d run, %0d failed, %0d checks, %0d errors", tests_run,
                 tests_failed, check_count, err_count + fail_count);
        if (err_count + fail_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        repeat (MAX_CYCLES) @(posedge clk);
        $display("watchdog: the tests did not finish within %0d cycles", MAX_CYCLES);
        $display("Test FAILED");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+src
+incdir+tests
src/csr_pkg.sv
src/csr_bus_if.sv
src/trap_if.sv
src/trap_ctrl.sv
src/irq_unit.sv
src/status_regs.sv
src/trap_regs.sv
src/csr_unit.sv
tests/tb_csr_unit.sv
